//--- hdl/simmem_settings.svh
// Build-time settings of the read-data bank
// Identifier count, slot count and payload width

`ifndef SIMMEM_SETTINGS_SVH
`define SIMMEM_SETTINGS_SVH

`default_nettype none

// Number of AXI identifiers, one linked-list queue each
`define SIMMEM_NUM_IDS 4

// Slots shared by all queues
`define SIMMEM_BANK_CAPACITY 8

// Message payload, identifier excluded
`define SIMMEM_CONTENT_WIDTH 16

`default_nettype wire

`endif

//--- hdl/simmem_pkg.sv
// Shared types of the read-data bank
// Identifier, slot address, slot mask and message types

`include "simmem_settings.svh"

`default_nettype none

package simmem_pkg;

  localparam int NumIds = `SIMMEM_NUM_IDS;
  localparam int BankCapacity = `SIMMEM_BANK_CAPACITY;
  localparam int ContentWidth = `SIMMEM_CONTENT_WIDTH;

  localparam int IdWidth = $clog2(NumIds);
  localparam int BankAddrWidth = $clog2(BankCapacity);

  typedef logic [IdWidth-1:0] axi_id_t;
  typedef logic [NumIds-1:0] id_onehot_t;

  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  // One bit per slot
  typedef logic [BankCapacity-1:0] slot_mask_t;

  typedef logic [ContentWidth-1:0] content_t;

  // Message as seen on the data ports
  typedef struct packed {
    axi_id_t  id;
    content_t content;
  } rdata_t;

endpackage

`default_nettype wire

//--- hdl/simmem_bank_ram.sv
// Small slot storage for the read-data bank
// One write port, one combinational read port, entry type as parameter

`timescale 1ns/1ns
`default_nettype none

module simmem_bank_ram #(
  parameter int Depth = 8,
  parameter type EntryT = logic [7:0]
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Write port, takes effect at the clock edge
  input  logic                     i_wr_en,
  input  logic [$clog2(Depth)-1:0] i_wr_addr,
  input  EntryT                    i_wr_data,

  // Read port, no latency
  input  logic [$clog2(Depth)-1:0] i_rd_addr,
  output EntryT                    o_rd_data
);

  EntryT mem_q [Depth];

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (i_wr_en) begin
      mem_q[i_wr_addr] <= i_wr_data;
    end
  end

  // Reads see the old entry during a write to the same slot
  assign o_rd_data = mem_q[i_rd_addr];

endmodule

`default_nettype wire

//--- hdl/simmem_slot_tracker.sv
// Slot occupancy of the read-data bank
// Reserved and filled bit per slot, lowest free slot search

`timescale 1ns/1ns
`default_nettype none

module simmem_slot_tracker import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       i_rsv_en,
  input  logic       i_fill_en,
  input  bank_addr_t i_fill_addr,
  input  slot_mask_t i_release_onehot,

  output bank_addr_t o_free_addr,
  output logic       o_has_free
);

  slot_mask_t reserved_q, reserved_d;
  slot_mask_t filled_q, filled_d;
  slot_mask_t free_mask;
  slot_mask_t rsv_mask;
  slot_mask_t fill_mask;

  ////////////////////////////////////////
  // Free slot search
  ////////////////////////////////////////

  assign free_mask = ~(reserved_q | filled_q);
  assign o_has_free = |free_mask;

  // Lowest index wins
  always_comb begin
    o_free_addr = '0;
    for (int i = BankCapacity - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        o_free_addr = bank_addr_t'(i);
      end
    end
  end

  ////////////////////////////////////////
  // Occupancy update
  ////////////////////////////////////////

  // Reserve, fill and release always hit distinct slots
  assign rsv_mask = i_rsv_en ? (slot_mask_t'(1) << o_free_addr) : '0;
  assign fill_mask = i_fill_en ? (slot_mask_t'(1) << i_fill_addr) : '0;

  assign reserved_d = (reserved_q | rsv_mask) & ~fill_mask & ~i_release_onehot;
  assign filled_d = (filled_q | fill_mask) & ~i_release_onehot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reserved_q <= '0;
      filled_q <= '0;
    end else begin
      reserved_q <= reserved_d;
      filled_q <= filled_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/simmem_id_queues.sv
// Per-identifier linked-list queues over the shared slots
// Head, middle and tail pointers, counts, and two copies of the links

`timescale 1ns/1ns
`default_nettype none

module simmem_id_queues import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Reservation from the tracker and requester
  input  logic       i_rsv_en,
  input  id_onehot_t i_rsv_id_onehot,
  input  bank_addr_t i_rsv_addr,

  // Incoming message
  input  logic       i_in_valid,
  input  axi_id_t    i_in_id,

  // Pop from the arbiter
  input  id_onehot_t i_pop_id_onehot,

  output logic       o_in_ready,
  output logic       o_fill_en,
  output bank_addr_t o_fill_addr,
  output bank_addr_t o_tail_addr [NumIds],
  output id_onehot_t o_tail_filled
);

  // Counts go up to the full capacity
  typedef logic [BankAddrWidth:0] count_t;

  // Head is the newest slot, middle the oldest unfilled, tail the oldest
  bank_addr_t head_q [NumIds];
  bank_addr_t mid_q [NumIds];
  bank_addr_t tail_q [NumIds];
  bank_addr_t head_d [NumIds];
  bank_addr_t mid_d [NumIds];
  bank_addr_t tail_d [NumIds];

  count_t rsv_len_q [NumIds];
  count_t fill_len_q [NumIds];
  count_t rsv_len_d [NumIds];
  count_t fill_len_d [NumIds];
  count_t total_len [NumIds];

  id_onehot_t rsv_hit;
  id_onehot_t fill_hit;

  // Link storage, written once and read by two pointers
  logic       link_wr_en;
  bank_addr_t link_wr_addr;
  bank_addr_t tail_rd_addr;
  bank_addr_t mid_link;
  bank_addr_t tail_link;

  assign o_in_ready = i_in_valid && (rsv_len_q[i_in_id] != '0);
  assign o_fill_en = o_in_ready;
  assign o_fill_addr = mid_q[i_in_id];

  ////////////////////////////////////////
  // Pointer and count update
  ////////////////////////////////////////

  for (genvar i = 0; i < NumIds; i++) begin : gen_queue
    assign rsv_hit[i] = i_rsv_en && i_rsv_id_onehot[i];
    assign fill_hit[i] = o_fill_en && (i_in_id == axi_id_t'(i));
    assign total_len[i] = rsv_len_q[i] + fill_len_q[i];

    assign rsv_len_d[i] = rsv_len_q[i] + count_t'(rsv_hit[i]) - count_t'(fill_hit[i]);
    assign fill_len_d[i] = fill_len_q[i] + count_t'(fill_hit[i]) - count_t'(i_pop_id_onehot[i]);

    assign head_d[i] = rsv_hit[i] ? i_rsv_addr : head_q[i];

    // Middle jumps to the new slot once no unfilled slot is left
    always_comb begin
      mid_d[i] = mid_q[i];
      if (rsv_hit[i] && (rsv_len_q[i] == count_t'(fill_hit[i]))) begin
        mid_d[i] = i_rsv_addr;
      end else if (fill_hit[i]) begin
        mid_d[i] = mid_link;
      end
    end

    // Tail restarts at the new slot when the queue drains
    always_comb begin
      tail_d[i] = tail_q[i];
      if (total_len[i] == count_t'(i_pop_id_onehot[i])) begin
        if (rsv_hit[i]) begin
          tail_d[i] = i_rsv_addr;
        end
      end else if (i_pop_id_onehot[i]) begin
        tail_d[i] = tail_link;
      end
    end

    assign o_tail_addr[i] = tail_q[i];
    assign o_tail_filled[i] = fill_len_q[i] != '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '{default: '0};
      mid_q <= '{default: '0};
      tail_q <= '{default: '0};
      rsv_len_q <= '{default: '0};
      fill_len_q <= '{default: '0};
    end else begin
      head_q <= head_d;
      mid_q <= mid_d;
      tail_q <= tail_d;
      rsv_len_q <= rsv_len_d;
      fill_len_q <= fill_len_d;
    end
  end

  ////////////////////////////////////////
  // Link storage
  ////////////////////////////////////////

  // New slot becomes the successor of the old head
  always_comb begin
    link_wr_en = 1'b0;
    link_wr_addr = '0;
    tail_rd_addr = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (rsv_hit[i]) begin
        link_wr_en = total_len[i] != '0;
        link_wr_addr = head_q[i];
      end
      if (i_pop_id_onehot[i]) begin
        tail_rd_addr = tail_q[i];
      end
    end
  end

  simmem_bank_ram #(
    .Depth (BankCapacity),
    .EntryT(bank_addr_t)
  ) i_mid_link (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .i_wr_en  (link_wr_en),
    .i_wr_addr(link_wr_addr),
    .i_wr_data(i_rsv_addr),
    .i_rd_addr(o_fill_addr),
    .o_rd_data(mid_link)
  );

  simmem_bank_ram #(
    .Depth (BankCapacity),
    .EntryT(bank_addr_t)
  ) i_tail_link (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .i_wr_en  (link_wr_en),
    .i_wr_addr(link_wr_addr),
    .i_wr_data(i_rsv_addr),
    .i_rd_addr(tail_rd_addr),
    .o_rd_data(tail_link)
  );

endmodule

`default_nettype wire

//--- hdl/simmem_release_arbiter.sv
// Release arbiter of the read-data bank
// Picks the lowest eligible identifier and holds the output register

`timescale 1ns/1ns
`default_nettype none

module simmem_release_arbiter import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  bank_addr_t i_tail_addr [NumIds],
  input  id_onehot_t i_tail_filled,
  input  slot_mask_t i_release_en,
  input  logic       i_out_ready,

  output logic       o_out_valid,
  output axi_id_t    o_out_id,
  output bank_addr_t o_out_addr,
  output id_onehot_t o_pop_id_onehot,
  output slot_mask_t o_released_onehot
);

  id_onehot_t eligible;
  logic       sel_valid;
  axi_id_t    sel_id;
  logic       load;
  logic       handshake;

  logic       out_valid_q;
  axi_id_t    out_id_q;
  bank_addr_t out_addr_q;

  ////////////////////////////////////////
  // Selection
  ////////////////////////////////////////

  // Oldest message of an identifier, and its slot is enabled
  for (genvar i = 0; i < NumIds; i++) begin : gen_eligible
    assign eligible[i] = i_tail_filled[i] && i_release_en[i_tail_addr[i]];
  end

  assign sel_valid = |eligible;

  always_comb begin
    sel_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel_id = axi_id_t'(i);
      end
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  // Only an empty register takes a new message
  assign load = !out_valid_q && sel_valid;
  assign handshake = out_valid_q && i_out_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_id_q <= '0;
      out_addr_q <= '0;
    end else if (load) begin
      out_valid_q <= 1'b1;
      out_id_q <= sel_id;
      out_addr_q <= i_tail_addr[sel_id];
    end else if (handshake) begin
      out_valid_q <= 1'b0;
    end
  end

  assign o_out_valid = out_valid_q;
  assign o_out_id = out_id_q;
  assign o_out_addr = out_addr_q;

  // Pulses on the handshake cycle only
  assign o_pop_id_onehot = handshake ? (id_onehot_t'(1) << out_id_q) : '0;
  assign o_released_onehot = handshake ? (slot_mask_t'(1) << out_addr_q) : '0;

endmodule

`default_nettype wire

//--- hdl/simmem_read_data_bank.sv
// Read-data bank of the simulated memory controller
// Slot tracker, identifier queues, release arbiter and message storage

`timescale 1ns/1ns
`default_nettype none

module simmem_read_data_bank import simmem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Reservation side
  input  id_onehot_t rsv_req_id_onehot_i,
  input  logic       rsv_valid_i,
  output bank_addr_t rsv_addr_o,
  output logic       rsv_ready_o,

  // Release control
  input  slot_mask_t release_en_i,
  output slot_mask_t released_addr_onehot_o,

  // Messages from the real controller
  input  rdata_t     data_i,
  input  logic       in_data_valid_i,
  output logic       in_data_ready_o,

  // Messages to the requester
  output rdata_t     data_o,
  output logic       out_data_valid_o,
  input  logic       out_data_ready_i
);

  logic       rsv_en;
  logic       fill_en;
  bank_addr_t fill_addr;

  bank_addr_t tail_addr [NumIds];
  id_onehot_t tail_filled;
  id_onehot_t pop_id_onehot;
  slot_mask_t released_onehot;

  axi_id_t    out_id;
  bank_addr_t out_addr;
  content_t   out_content;

  assign rsv_en = rsv_valid_i && rsv_ready_o;

  ////////////////////////////////////////
  // Slot bookkeeping
  ////////////////////////////////////////

  simmem_slot_tracker i_slot_tracker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .i_rsv_en        (rsv_en),
    .i_fill_en       (fill_en),
    .i_fill_addr     (fill_addr),
    .i_release_onehot(released_onehot),
    .o_free_addr     (rsv_addr_o),
    .o_has_free      (rsv_ready_o)
  );

  simmem_id_queues i_id_queues (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_rsv_en       (rsv_en),
    .i_rsv_id_onehot(rsv_req_id_onehot_i),
    .i_rsv_addr     (rsv_addr_o),
    .i_in_valid     (in_data_valid_i),
    .i_in_id        (data_i.id),
    .i_pop_id_onehot(pop_id_onehot),
    .o_in_ready     (in_data_ready_o),
    .o_fill_en      (fill_en),
    .o_fill_addr    (fill_addr),
    .o_tail_addr    (tail_addr),
    .o_tail_filled  (tail_filled)
  );

  ////////////////////////////////////////
  // Release path
  ////////////////////////////////////////

  simmem_release_arbiter i_release_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_tail_addr      (tail_addr),
    .i_tail_filled    (tail_filled),
    .i_release_en     (release_en_i),
    .i_out_ready      (out_data_ready_i),
    .o_out_valid      (out_data_valid_o),
    .o_out_id         (out_id),
    .o_out_addr       (out_addr),
    .o_pop_id_onehot  (pop_id_onehot),
    .o_released_onehot(released_onehot)
  );

  assign released_addr_onehot_o = released_onehot;

  // Payload only, the identifier comes back from the arbiter
  simmem_bank_ram #(
    .Depth (BankCapacity),
    .EntryT(content_t)
  ) i_msg_ram (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .i_wr_en  (fill_en),
    .i_wr_addr(fill_addr),
    .i_wr_data(data_i.content),
    .i_rd_addr(out_addr),
    .o_rd_data(out_content)
  );

  assign data_o.id = out_id;
  assign data_o.content = out_content;

endmodule

`default_nettype wire

//--- tests/simmem_read_data_bank_asserts.sv
// Bound assertions on the read-data bank handshakes
// Output stability under back-pressure, release pulse shape, input ready

`timescale 1ns/1ns
`default_nettype none

module simmem_read_data_bank_asserts import simmem_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input rdata_t     data_o,
  input logic       out_data_valid_o,
  input logic       out_data_ready_i,
  input slot_mask_t released_addr_onehot_o,
  input logic       in_data_valid_i,
  input logic       in_data_ready_o
);

  // Failures seen so far, read by the testbench
  int fail_count;

  initial fail_count = 0;

  // Presented message holds until it is taken
  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_data_valid_o && !out_data_ready_i) |=> (out_data_valid_o && $stable(data_o))
  ) else begin
    fail_count++;
    $error("data_o changed while out_data_ready_i was low");
  end

  // At most one slot is released per cycle
  a_release_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(released_addr_onehot_o)
  ) else begin
    fail_count++;
    $error("released_addr_onehot_o has more than one bit set");
  end

  a_in_ready_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_data_ready_o |-> in_data_valid_i
  ) else begin
    fail_count++;
    $error("in_data_ready_o is high without in_data_valid_i");
  end

endmodule

bind simmem_read_data_bank simmem_read_data_bank_asserts i_asserts (
  .clk_i                 (clk_i),
  .rst_ni                (rst_ni),
  .data_o                (data_o),
  .out_data_valid_o      (out_data_valid_o),
  .out_data_ready_i      (out_data_ready_i),
  .released_addr_onehot_o(released_addr_onehot_o),
  .in_data_valid_i       (in_data_valid_i),
  .in_data_ready_o       (in_data_ready_o)
);

`default_nettype wire

//--- tests/tb_simmem_read_data_bank.sv
// Testbench of the read-data bank
// Clock, reset, stimulus table, reference model and checks

`timescale 1ns/1ns
`default_nettype none

module tb_simmem_read_data_bank import simmem_pkg::*; ();

  localparam int Timeout = 50;
  localparam int HoldCycles = 12;

  typedef enum logic [2:0] {OP_STATUS, OP_RSV, OP_SEND, OP_DRAIN, OP_HOLD} op_t;

  // Zero payload means a random one
  typedef struct packed {
    op_t        op;
    axi_id_t    id;
    content_t   payload;
    slot_mask_t mask;
    logic [3:0] count;
  } step_t;

  logic       clk_i;
  logic       rst_ni;
  id_onehot_t rsv_req_id_onehot_i;
  logic       rsv_valid_i;
  bank_addr_t rsv_addr_o;
  logic       rsv_ready_o;
  slot_mask_t release_en_i;
  slot_mask_t released_addr_onehot_o;
  rdata_t     data_i;
  logic       in_data_valid_i;
  logic       in_data_ready_o;
  rdata_t     data_o;
  logic       out_data_valid_o;
  logic       out_data_ready_i;

  step_t steps [$];

  // Reference model, slots per identifier in reservation order
  bank_addr_t model_q [NumIds][$];
  int         fill_cnt [NumIds];
  content_t   model_mem [BankCapacity];
  slot_mask_t free_mask;

  logic [31:0] rnd_state;
  int errors;
  int checks;
  int timeouts;

  simmem_read_data_bank i_dut (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rnd_state = xorshift32(rnd_state);
    return rnd_state;
  endfunction

  function automatic bank_addr_t lowest_free();
    for (int i = 0; i < BankCapacity; i++) begin
      if (free_mask[i]) begin
        return bank_addr_t'(i);
      end
    end
    return '0;
  endfunction

  // Lowest identifier whose oldest slot is filled and enabled
  function automatic int pick_id(input slot_mask_t mask);
    for (int i = 0; i < NumIds; i++) begin
      if (fill_cnt[i] > 0 && mask[model_q[i][0]]) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic add_step(input op_t op, input axi_id_t id, input content_t payload,
                          input slot_mask_t mask, input logic [3:0] count);
    steps.push_back(step_t'{op, id, payload, mask, count});
  endtask

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////

  task automatic compare_rsv_status();
    next_cycle();
    #1;
    check_value("rsv_ready_o", rsv_ready_o, free_mask != '0);
    if (free_mask != '0) begin
      check_value("rsv_addr_o", rsv_addr_o, lowest_free());
    end
  endtask

  task automatic reserve_slot(input axi_id_t id);
    int wait_cnt;
    bank_addr_t exp_addr;
    wait_cnt = 0;
    next_cycle();
    rsv_valid_i = 1'b1;
    rsv_req_id_onehot_i = id_onehot_t'(1) << id;
    #1;
    while (!rsv_ready_o && wait_cnt < Timeout) begin
      next_cycle();
      #1;
      wait_cnt++;
    end
    if (!rsv_ready_o) begin
      timeouts++;
      $display("Timeout: no free slot came up for identifier %0d", id);
    end else begin
      exp_addr = lowest_free();
      check_value("rsv_addr_o", rsv_addr_o, exp_addr);
      free_mask[exp_addr] = 1'b0;
      model_q[id].push_back(exp_addr);
    end
    next_cycle();
    rsv_valid_i = 1'b0;
    rsv_req_id_onehot_i = '0;
  endtask

  task automatic send_message(input axi_id_t id, input content_t payload);
    int wait_cnt;
    logic exp_ready;
    content_t value;
    wait_cnt = 0;
    value = (payload != '0) ? payload : content_t'(next_random());
    exp_ready = fill_cnt[id] < model_q[id].size();
    next_cycle();
    in_data_valid_i = 1'b1;
    data_i.id = id;
    data_i.content = value;
    #1;
    if (exp_ready) begin
      while (!in_data_ready_o && wait_cnt < Timeout) begin
        next_cycle();
        #1;
        wait_cnt++;
      end
      if (!in_data_ready_o) begin
        timeouts++;
        $display("Timeout: the bank never accepted data for identifier %0d", id);
      end else begin
        model_mem[model_q[id][fill_cnt[id]]] = value;
        fill_cnt[id]++;
      end
    end else begin
      check_value("in_data_ready_o", in_data_ready_o, 1'b0);
    end
    next_cycle();
    in_data_valid_i = 1'b0;
    data_i = '0;
  endtask

  task automatic drain_messages(input slot_mask_t mask, input int count);
    int got;
    int wait_cnt;
    int exp_id;
    bank_addr_t slot;
    logic [31:0] rnd;
    got = 0;
    wait_cnt = 0;
    next_cycle();
    release_en_i = mask;
    while (got < count && wait_cnt < Timeout) begin
      rnd = next_random();
      out_data_ready_i = rnd[0];
      #1;
      if (out_data_valid_o && out_data_ready_i) begin
        exp_id = pick_id(mask);
        if (exp_id < 0) begin
          errors++;
          $display("A message left although no message was eligible");
        end else begin
          slot = model_q[exp_id][0];
          check_value("data_o.id", data_o.id, exp_id);
          check_value("data_o.content", data_o.content, model_mem[slot]);
          check_value("released_addr_onehot_o", released_addr_onehot_o,
                      slot_mask_t'(1) << slot);
          void'(model_q[exp_id].pop_front());
          fill_cnt[exp_id]--;
          free_mask[slot] = 1'b1;
        end
        got++;
        wait_cnt = 0;
      end else begin
        check_value("released_addr_onehot_o", released_addr_onehot_o, '0);
        wait_cnt++;
      end
      next_cycle();
    end
    // Closing the mask keeps the arbiter from loading another message
    release_en_i = '0;
    out_data_ready_i = 1'b0;
    if (got < count) begin
      timeouts++;
      $display("Timeout: only %0d of %0d messages left the bank", got, count);
    end
  endtask

  task automatic hold_blocked(input slot_mask_t mask);
    next_cycle();
    release_en_i = mask;
    out_data_ready_i = 1'b1;
    for (int i = 0; i < HoldCycles; i++) begin
      #1;
      check_value("out_data_valid_o", out_data_valid_o, 1'b0);
      next_cycle();
    end
    release_en_i = '0;
    out_data_ready_i = 1'b0;
  endtask

  task automatic build_table();
    add_step(OP_STATUS, 0, 0, 0, 0);
    add_step(OP_RSV, 0, 0, 0, 0);
    add_step(OP_RSV, 1, 0, 0, 0);
    add_step(OP_RSV, 0, 0, 0, 0);
    add_step(OP_RSV, 2, 0, 0, 0);
    add_step(OP_SEND, 3, 16'h3333, 0, 0);
    add_step(OP_SEND, 1, 16'h1111, 0, 0);
    add_step(OP_SEND, 0, 0, 0, 0);
    add_step(OP_SEND, 0, 16'h0a0a, 0, 0);
    add_step(OP_SEND, 0, 16'h0bad, 0, 0);
    add_step(OP_SEND, 2, 0, 0, 0);
    add_step(OP_DRAIN, 0, 0, 8'hff, 4);
    add_step(OP_STATUS, 0, 0, 0, 0);
    // Fill the whole bank
    for (int i = 0; i < BankCapacity; i++) begin
      add_step(OP_RSV, axi_id_t'(i), 0, 0, 0);
    end
    add_step(OP_STATUS, 0, 0, 0, 0);
    add_step(OP_SEND, 3, 0, 0, 0);
    add_step(OP_SEND, 2, 0, 0, 0);
    add_step(OP_SEND, 1, 0, 0, 0);
    add_step(OP_HOLD, 0, 0, 8'hf1, 0);
    add_step(OP_DRAIN, 0, 0, 8'h08, 1);
    add_step(OP_STATUS, 0, 0, 0, 0);
    add_step(OP_RSV, 1, 0, 0, 0);
    add_step(OP_STATUS, 0, 0, 0, 0);
    add_step(OP_SEND, 0, 0, 0, 0);
    add_step(OP_SEND, 0, 0, 0, 0);
    add_step(OP_SEND, 1, 0, 0, 0);
    add_step(OP_SEND, 2, 0, 0, 0);
    add_step(OP_SEND, 3, 0, 0, 0);
    add_step(OP_SEND, 1, 0, 0, 0);
    add_step(OP_SEND, 1, 16'hdead, 0, 0);
    add_step(OP_DRAIN, 0, 0, 8'hff, 8);
    add_step(OP_STATUS, 0, 0, 0, 0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    rsv_req_id_onehot_i = '0;
    rsv_valid_i = 1'b0;
    release_en_i = '0;
    data_i = '0;
    in_data_valid_i = 1'b0;
    out_data_ready_i = 1'b0;
    rnd_state = 32'h0673f6f5;
    errors = 0;
    checks = 0;
    timeouts = 0;
    free_mask = '1;
    fill_cnt = '{default: 0};
    build_table();

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    #1;
    check_value("out_data_valid_o", out_data_valid_o, 1'b0);
    check_value("in_data_ready_o", in_data_ready_o, 1'b0);
    check_value("released_addr_onehot_o", released_addr_onehot_o, '0);

    for (int s = 0; s < steps.size(); s++) begin
      case (steps[s].op)
        OP_STATUS: compare_rsv_status();
        OP_RSV:    reserve_slot(steps[s].id);
        OP_SEND:   send_message(steps[s].id, steps[s].payload);
        OP_DRAIN:  drain_messages(steps[s].mask, int'(steps[s].count));
        OP_HOLD:   hold_blocked(steps[s].mask);
        default: begin
          errors++;
          $display("Unknown operation in the stimulus table at step %0d", s);
        end
      endcase
      if (timeouts != 0) begin
        break;
      end
    end

    repeat (2) next_cycle();
    errors += i_dut.i_asserts.fail_count;
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/simmem_pkg.sv
hdl/simmem_bank_ram.sv
hdl/simmem_slot_tracker.sv
hdl/simmem_id_queues.sv
hdl/simmem_release_arbiter.sv
hdl/simmem_read_data_bank.sv
tests/simmem_read_data_bank_asserts.sv
tests/tb_simmem_read_data_bank.sv

//--- Bender.yml
package:
  name: simmem_read_data_bank

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/simmem_pkg.sv
      - hdl/simmem_bank_ram.sv
      - hdl/simmem_slot_tracker.sv
      - hdl/simmem_id_queues.sv
      - hdl/simmem_release_arbiter.sv
      - hdl/simmem_read_data_bank.sv
  - target: test
    files:
      - tests/simmem_read_data_bank_asserts.sv
      - tests/tb_simmem_read_data_bank.sv
